// File: verilog/mem_game_pkg.sv
package mem_game_pkg;

    // display digit or button label, 0 to 3
    typedef logic [1:0] digit_t;

    // button position, 0 is the leftmost button
    typedef logic [1:0] pos_t;

    // stage index, 0 to 4
    typedef logic [2:0] stage_t;

    // the stage rules are written for exactly five stages
    localparam int NUM_STAGES = 5;

    // encoding shared with the game's top-level FSM
    typedef enum logic [2:0] {
        GAME_IDLE = 3'd0,
        GAME_RUN  = 3'd1,
        GAME_WON  = 3'd2,
        GAME_LOST = 3'd3
    } game_state_t;

    // press judge FSM
    typedef enum logic [1:0] {
        // no puzzle drawn since reset
        ST_WAIT    = 2'd0,
        ST_ARMED   = 2'd1,
        ST_CLEARED = 2'd2
    } judge_state_t;

endpackage

// File: verilog/puzzle_source.sv
`timescale 1ns/1ns

module puzzle_source import mem_game_pkg::*; #(
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  activate_rand,
    output logic [NUM_STAGES-1:0] load_en,
    output digit_t                load_display,
    output digit_t                load_label_0,
    output digit_t                load_label_1,
    output digit_t                load_label_2,
    output digit_t                load_label_3,
    output logic                  puzzle_ready
);

    logic [15:0]           lfsr;
    logic [NUM_STAGES-1:0] load_ptr;
    pos_t                  rot;
    logic                  swap;
    digit_t                base [4];

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1, free running
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
    end

    // one-hot pointer walks slots 0..4 in the five cycles after activate_rand
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_ptr     <= '0;
            puzzle_ready <= 1'b0;
        end else if (activate_rand) begin
            load_ptr     <= NUM_STAGES'(1);
            puzzle_ready <= 1'b0;
        end else begin
            load_ptr <= load_ptr << 1;
            if (load_ptr[NUM_STAGES-1]) begin
                puzzle_ready <= 1'b1;
            end
        end
    end

    assign load_en = load_ptr;

    // draw from spread lfsr bits so neighbouring slots differ more
    assign load_display = lfsr[1:0];
    assign rot          = lfsr[6:5];
    assign swap         = lfsr[11];

    // identity with optional middle swap, then rotated: eight permutations
    always_comb begin
        base[0] = 2'd0;
        base[1] = swap ? 2'd2 : 2'd1;
        base[2] = swap ? 2'd1 : 2'd2;
        base[3] = 2'd3;
    end

    // index arithmetic wraps in two bits
    assign load_label_0 = base[rot];
    assign load_label_1 = base[rot + 2'd1];
    assign load_label_2 = base[rot + 2'd2];
    assign load_label_3 = base[rot + 2'd3];

endmodule

// File: verilog/stage_slot.sv
`timescale 1ns/1ns

module stage_slot import mem_game_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   load_en,
    input  digit_t load_display,
    input  digit_t load_label_0,
    input  digit_t load_label_1,
    input  digit_t load_label_2,
    input  digit_t load_label_3,
    input  logic   rec_en,
    input  pos_t   rec_pos,
    input  digit_t rec_label,
    input  logic   clr_rec,
    output digit_t display,
    output digit_t label_0,
    output digit_t label_1,
    output digit_t label_2,
    output digit_t label_3,
    output pos_t   rec_pos_out,
    output digit_t rec_label_out
);

    // puzzle contents for this stage
    always_ff @(posedge clk) begin
        if (load_en) begin
            display <= load_display;
            label_0 <= load_label_0;
            label_1 <= load_label_1;
            label_2 <= load_label_2;
            label_3 <= load_label_3;
        end
    end

    // correct press made at this stage, read back by later stage rules
    always_ff @(posedge clk) begin
        if (!rst_n || clr_rec) begin
            rec_pos_out   <= '0;
            rec_label_out <= '0;
        end else if (rec_en) begin
            rec_pos_out   <= rec_pos;
            rec_label_out <= rec_label;
        end
    end

endmodule

// File: verilog/press_judge.sv
`timescale 1ns/1ns

module press_judge import mem_game_pkg::*; #(
    parameter logic [2:0] MODULE_ID = 3'd2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  strobe,
    input  logic [5:0]            button,
    input  game_state_t           game_state_in,
    input  logic [2:0]            playing_state_in,
    input  logic                  activate_rand,
    input  logic                  puzzle_ready,
    input  digit_t                slot_display [NUM_STAGES],
    input  digit_t                slot_label_0 [NUM_STAGES],
    input  digit_t                slot_label_1 [NUM_STAGES],
    input  digit_t                slot_label_2 [NUM_STAGES],
    input  digit_t                slot_label_3 [NUM_STAGES],
    input  pos_t                  slot_rec_pos [NUM_STAGES],
    input  digit_t                slot_rec_label [NUM_STAGES],
    output logic [NUM_STAGES-1:0] rec_en,
    output pos_t                  rec_pos,
    output digit_t                rec_label,
    output logic                  clr_rec,
    output pos_t                  mem_pos,
    output stage_t                stage,
    output logic                  mem_error,
    output logic                  mem_clear,
    output digit_t                display_num,
    output digit_t                label_0,
    output digit_t                label_1,
    output digit_t                label_2,
    output digit_t                label_3
);

    judge_state_t state;
    logic         activate_q;
    logic         one_hot;
    pos_t         press_pos;
    logic         accept;
    logic         correct;
    pos_t         rule_pos;
    digit_t       cur_disp;
    digit_t       cur_lab [4];

    // position whose label equals value; labels are a permutation
    function automatic pos_t find_pos(input digit_t lab [4], input digit_t value);
        pos_t p;
        p = '0;
        for (int i = 0; i < 4; i++) begin
            if (lab[i] == value) begin
                p = pos_t'(i);
            end
        end
        return p;
    endfunction

    // current stage's puzzle
    assign cur_disp   = slot_display[stage];
    assign cur_lab[0] = slot_label_0[stage];
    assign cur_lab[1] = slot_label_1[stage];
    assign cur_lab[2] = slot_label_2[stage];
    assign cur_lab[3] = slot_label_3[stage];

    assign display_num = cur_disp;
    assign label_0     = cur_lab[0];
    assign label_1     = cur_lab[1];
    assign label_2     = cur_lab[2];
    assign label_3     = cur_lab[3];

    // button[5:4] are navigation and take no part here
    always_comb begin
        one_hot   = 1'b1;
        press_pos = '0;
        case (button[3:0])
            4'b0001: press_pos = 2'd0;
            4'b0010: press_pos = 2'd1;
            4'b0100: press_pos = 2'd2;
            4'b1000: press_pos = 2'd3;
            default: one_hot   = 1'b0;
        endcase
    end

    assign accept = strobe && one_hot && puzzle_ready && (state == ST_ARMED)
                 && (game_state_in == GAME_RUN) && (playing_state_in == MODULE_ID);

    // stage rules
    always_comb begin
        rule_pos = '0;
        case (stage)
            3'd0: begin
                case (cur_disp)
                    2'd0, 2'd1: rule_pos = 2'd1;
                    2'd2:       rule_pos = 2'd2;
                    default:    rule_pos = 2'd3;
                endcase
            end
            3'd1: begin
                case (cur_disp)
                    2'd0:    rule_pos = find_pos(cur_lab, 2'd3);
                    2'd2:    rule_pos = 2'd0;
                    default: rule_pos = slot_rec_pos[0];
                endcase
            end
            3'd2: begin
                case (cur_disp)
                    2'd0:    rule_pos = find_pos(cur_lab, slot_rec_label[1]);
                    2'd1:    rule_pos = find_pos(cur_lab, slot_rec_label[0]);
                    2'd2:    rule_pos = 2'd2;
                    default: rule_pos = find_pos(cur_lab, 2'd3);
                endcase
            end
            3'd3: begin
                case (cur_disp)
                    2'd0:    rule_pos = slot_rec_pos[0];
                    2'd1:    rule_pos = 2'd0;
                    default: rule_pos = slot_rec_pos[1];
                endcase
            end
            default: begin
                // label from an earlier stage, note 2 and 3 cross over
                case (cur_disp)
                    2'd0:    rule_pos = find_pos(cur_lab, slot_rec_label[0]);
                    2'd1:    rule_pos = find_pos(cur_lab, slot_rec_label[1]);
                    2'd2:    rule_pos = find_pos(cur_lab, slot_rec_label[3]);
                    default: rule_pos = find_pos(cur_lab, slot_rec_label[2]);
                endcase
            end
        endcase
    end

    assign correct = (press_pos == rule_pos);

    // record into the current stage's slot on a correct press
    always_comb begin
        rec_en = '0;
        if (accept && correct) begin
            rec_en[stage] = 1'b1;
        end
    end

    assign rec_pos   = press_pos;
    assign rec_label = cur_lab[press_pos];
    assign clr_rec   = activate_q || (accept && !correct);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_WAIT;
            activate_q <= 1'b0;
            stage      <= '0;
            mem_pos    <= '0;
            mem_error  <= 1'b0;
            mem_clear  <= 1'b0;
        end else begin
            activate_q <= activate_rand;
            mem_error  <= accept && !correct;
            if (accept) begin
                mem_pos <= press_pos;
            end
            // new puzzle being loaded, restart from stage 0
            if (activate_q) begin
                state     <= ST_ARMED;
                stage     <= '0;
                mem_clear <= 1'b0;
            end else if (accept) begin
                if (!correct) begin
                    stage <= '0;
                end else if (stage == stage_t'(NUM_STAGES - 1)) begin
                    mem_clear <= 1'b1;
                    state     <= ST_CLEARED;
                end else begin
                    stage <= stage + stage_t'(1);
                end
            end
        end
    end

endmodule

// File: verilog/mem_game.sv
`timescale 1ns/1ns

module mem_game import mem_game_pkg::*; #(
    parameter logic [2:0]  MODULE_ID = 3'd2,
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  button,
    input  logic        strobe,
    input  game_state_t game_state_in,
    input  logic [2:0]  playing_state_in,
    input  logic        activate_rand,
    output logic        mem_error,
    output logic        mem_clear,
    output pos_t        mem_pos,
    output stage_t      stage,
    output digit_t      display_num,
    output digit_t      label_0,
    output digit_t      label_1,
    output digit_t      label_2,
    output digit_t      label_3,
    output logic        puzzle_ready
);

    logic [NUM_STAGES-1:0] load_en;
    digit_t                load_display;
    digit_t                load_label_0;
    digit_t                load_label_1;
    digit_t                load_label_2;
    digit_t                load_label_3;

    logic [NUM_STAGES-1:0] rec_en;
    pos_t                  rec_pos;
    digit_t                rec_label;
    logic                  clr_rec;

    digit_t slot_display   [NUM_STAGES];
    digit_t slot_label_0   [NUM_STAGES];
    digit_t slot_label_1   [NUM_STAGES];
    digit_t slot_label_2   [NUM_STAGES];
    digit_t slot_label_3   [NUM_STAGES];
    pos_t   slot_rec_pos   [NUM_STAGES];
    digit_t slot_rec_label [NUM_STAGES];

    puzzle_source #(
        .LFSR_SEED(LFSR_SEED)
    ) u_source (
        .clk          (clk),
        .rst_n        (rst_n),
        .activate_rand(activate_rand),
        .load_en      (load_en),
        .load_display (load_display),
        .load_label_0 (load_label_0),
        .load_label_1 (load_label_1),
        .load_label_2 (load_label_2),
        .load_label_3 (load_label_3),
        .puzzle_ready (puzzle_ready)
    );

    // one slot per stage, shared load and record buses
    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_slot
        stage_slot u_slot (
            .clk          (clk),
            .rst_n        (rst_n),
            .load_en      (load_en[i]),
            .load_display (load_display),
            .load_label_0 (load_label_0),
            .load_label_1 (load_label_1),
            .load_label_2 (load_label_2),
            .load_label_3 (load_label_3),
            .rec_en       (rec_en[i]),
            .rec_pos      (rec_pos),
            .rec_label    (rec_label),
            .clr_rec      (clr_rec),
            .display      (slot_display[i]),
            .label_0      (slot_label_0[i]),
            .label_1      (slot_label_1[i]),
            .label_2      (slot_label_2[i]),
            .label_3      (slot_label_3[i]),
            .rec_pos_out  (slot_rec_pos[i]),
            .rec_label_out(slot_rec_label[i])
        );
    end

    press_judge #(
        .MODULE_ID(MODULE_ID)
    ) u_judge (
        .clk             (clk),
        .rst_n           (rst_n),
        .strobe          (strobe),
        .button          (button),
        .game_state_in   (game_state_in),
        .playing_state_in(playing_state_in),
        .activate_rand   (activate_rand),
        .puzzle_ready    (puzzle_ready),
        .slot_display    (slot_display),
        .slot_label_0    (slot_label_0),
        .slot_label_1    (slot_label_1),
        .slot_label_2    (slot_label_2),
        .slot_label_3    (slot_label_3),
        .slot_rec_pos    (slot_rec_pos),
        .slot_rec_label  (slot_rec_label),
        .rec_en          (rec_en),
        .rec_pos         (rec_pos),
        .rec_label       (rec_label),
        .clr_rec         (clr_rec),
        .mem_pos         (mem_pos),
        .stage           (stage),
        .mem_error       (mem_error),
        .mem_clear       (mem_clear),
        .display_num     (display_num),
        .label_0         (label_0),
        .label_1         (label_1),
        .label_2         (label_2),
        .label_3         (label_3)
    );

endmodule

// File: test/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: test/mem_game_tb.sv
`timescale 1ns/1ns

module mem_game_tb import mem_game_pkg::*; ();

    localparam logic [2:0]  MODULE_ID        = 3'd2;
    localparam logic [15:0] LFSR_SEED        = 16'h5A3C;
    localparam logic [31:0] SEED             = 32'ha802_0c0d;
    localparam int          NUM_SESSIONS     = 12;
    localparam int          SESSION_PRESSES  = 24;
    localparam int          DIRECTED_PRESSES = 48;
    localparam int          LOAD_CYCLES      = 10;
    localparam int          PLANNED_PRESSES  =
        DIRECTED_PRESSES + NUM_SESSIONS * (SESSION_PRESSES + 1);
    localparam int          TIMEOUT_CYCLES   =
        PLANNED_PRESSES * 20 + (NUM_SESSIONS + 4) * LOAD_CYCLES + 20;

    logic        clk;
    logic        rst_n;
    logic [5:0]  button;
    logic        strobe;
    game_state_t game_state_in;
    logic [2:0]  playing_state_in;
    logic        activate_rand;
    logic        mem_error;
    logic        mem_clear;
    logic        puzzle_ready;
    pos_t        mem_pos;
    stage_t      stage;
    digit_t      display_num;
    digit_t      label_0;
    digit_t      label_1;
    digit_t      label_2;
    digit_t      label_3;

    // player model with its own stage count and the correct presses so far
    stage_t m_stage;
    logic   m_ready;
    logic   m_clear;
    pos_t   m_pos;
    pos_t   h_pos [NUM_STAGES];
    digit_t h_label [NUM_STAGES];

    // each stage's puzzle as first shown after a load
    logic   seen [NUM_STAGES];
    digit_t seen_disp [NUM_STAGES];
    digit_t seen_lab [NUM_STAGES][4];

    clk_gen #(.PERIOD(8), .RESET_CYCLES(4)) u_clk (.clk(clk), .rst_n(rst_n));

    mem_game #(
        .MODULE_ID(MODULE_ID),
        .LFSR_SEED(LFSR_SEED)
    ) dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .button          (button),
        .strobe          (strobe),
        .game_state_in   (game_state_in),
        .playing_state_in(playing_state_in),
        .activate_rand   (activate_rand),
        .mem_error       (mem_error),
        .mem_clear       (mem_clear),
        .mem_pos         (mem_pos),
        .stage           (stage),
        .display_num     (display_num),
        .label_0         (label_0),
        .label_1         (label_1),
        .label_2         (label_2),
        .label_3         (label_3),
        .puzzle_ready    (puzzle_ready)
    );

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_pos(input pos_t actual, input pos_t expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s is %0d, expected %0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_stage(input stage_t actual, input stage_t expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s is %0d, expected %0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_digit(input digit_t actual, input digit_t expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s is %0d, expected %0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    function automatic digit_t label_at(input pos_t p);
        case (p)
            2'd0: return label_0;
            2'd1: return label_1;
            2'd2: return label_2;
            default: return label_3;
        endcase
    endfunction

    function automatic pos_t where_label(input digit_t v);
        pos_t p;
        p = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (label_at(pos_t'(i)) == v) begin
                p = pos_t'(i);
            end
        end
        return p;
    endfunction

    // the player's answer from what the display shows right now
    function automatic pos_t rule_answer();
        digit_t d;
        stage_t src;
        d = display_num;
        case (m_stage)
            3'd0: return (d == 2'd2) ? 2'd2 : ((d == 2'd3) ? 2'd3 : 2'd1);
            3'd1: return (d == 2'd0) ? where_label(2'd3) : ((d == 2'd2) ? 2'd0 : h_pos[0]);
            3'd2: begin
                case (d)
                    2'd0: return where_label(h_label[1]);
                    2'd1: return where_label(h_label[0]);
                    2'd2: return 2'd2;
                    default: return where_label(2'd3);
                endcase
            end
            3'd3: return (d == 2'd0) ? h_pos[0] : ((d == 2'd1) ? 2'd0 : h_pos[1]);
            default: begin
                // display 2 points at stage 3, display 3 at stage 2
                src = (d == 2'd2) ? 3'd3 : ((d == 2'd3) ? 3'd2 : stage_t'(d));
                return where_label(h_label[src]);
            end
        endcase
    endfunction

    task automatic clear_history();
        h_pos   = '{default: 2'd0};
        h_label = '{default: 2'd0};
    endtask

    task automatic check_outputs();
        check_stage(stage, m_stage, "stage");
        check_pos(mem_pos, m_pos, "mem_pos");
        check_flag(mem_clear, m_clear, "mem_clear");
    endtask

    // every value 0..3 must sit at some position
    task automatic check_labels();
        for (int v = 0; v < 4; v++) begin
            check_digit(label_at(where_label(digit_t'(v))), digit_t'(v), "label permutation");
        end
    endtask

    // a restart after a wrong press brings back the same puzzle
    task automatic check_same_puzzle();
        if (seen[m_stage]) begin
            check_digit(display_num, seen_disp[m_stage], "display_num on revisit");
            for (int i = 0; i < 4; i++) begin
                check_digit(label_at(pos_t'(i)), seen_lab[m_stage][i], "label on revisit");
            end
        end else begin
            seen[m_stage]      = 1'b1;
            seen_disp[m_stage] = display_num;
            for (int i = 0; i < 4; i++) begin
                seen_lab[m_stage][i] = label_at(pos_t'(i));
            end
        end
    endtask

    task automatic press(input logic [3:0] sel);
        logic   valid;
        pos_t   p;
        pos_t   ans;
        digit_t lab;
        p = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                p = pos_t'(i);
            end
        end
        valid = ($countones(sel) == 1) && m_ready && !m_clear
             && (game_state_in == GAME_RUN) && (playing_state_in == MODULE_ID);
        ans = rule_answer();
        lab = label_at(p);
        // navigation bits are random noise
        button = {2'($urandom), sel};
        strobe = 1'b1;
        @(negedge clk);
        strobe = 1'b0;
        button = '0;
        if (valid) begin
            m_pos = p;
        end
        if (valid && p != ans) begin
            m_stage = '0;
            clear_history();
            check_flag(mem_error, 1'b1, "mem_error after wrong press");
            check_outputs();
            @(negedge clk);
            check_flag(mem_error, 1'b0, "mem_error one cycle later");
        end else begin
            if (valid) begin
                h_pos[m_stage]   = p;
                h_label[m_stage] = lab;
                if (m_stage == stage_t'(NUM_STAGES - 1)) begin
                    m_clear = 1'b1;
                end else begin
                    m_stage = m_stage + 3'd1;
                end
            end
            check_flag(mem_error, 1'b0, "mem_error");
        end
        check_outputs();
        if (m_ready && !m_clear) begin
            check_labels();
            check_same_puzzle();
        end
    endtask

    task automatic load_puzzle();
        int waited;
        game_state_in    = GAME_RUN;
        playing_state_in = MODULE_ID;
        activate_rand    = 1'b1;
        @(negedge clk);
        activate_rand = 1'b0;
        m_stage = '0;
        m_clear = 1'b0;
        m_ready = 1'b0;
        clear_history();
        seen = '{default: 1'b0};
        // a press while the slots are still loading goes nowhere
        press(4'b0001 << 2'($urandom));
        check_flag(puzzle_ready, 1'b0, "puzzle_ready while loading");
        waited = 1;
        while (!puzzle_ready && waited < LOAD_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!puzzle_ready || waited > 5) begin
            $display("puzzle_ready did not rise within 5 cycles of activate_rand");
            abort_run();
        end
        m_ready = 1'b1;
        check_flag(mem_error, 1'b0, "mem_error after load");
        check_outputs();
        check_labels();
        check_same_puzzle();
    endtask

    task automatic play_correct(input int n);
        repeat (n) press(4'b0001 << rule_answer());
    endtask

    task automatic wrong_press();
        press(4'b0001 << (rule_answer() + pos_t'(32'd1 + $urandom % 3)));
    endtask

    task automatic drop_press(input int kind);
        logic [3:0] sel;
        sel = 4'b0001 << rule_answer();
        case (kind)
            0: begin
                game_state_in = game_state_t'(3'($urandom % 4));
                if (game_state_in == GAME_RUN) begin
                    game_state_in = GAME_WON;
                end
            end
            1: playing_state_in = MODULE_ID ^ 3'(32'd1 + $urandom % 7);
            default: begin
                sel = 4'($urandom);
                while ($countones(sel) == 1) begin
                    sel = 4'($urandom);
                end
            end
        endcase
        press(sel);
        game_state_in    = GAME_RUN;
        playing_state_in = MODULE_ID;
    endtask

    task automatic run_session();
        int pick;
        load_puzzle();
        repeat (SESSION_PRESSES) begin
            pick = int'($urandom % 10);
            if (pick < 6) begin
                play_correct(1);
            end else if (pick == 6) begin
                wrong_press();
            end else begin
                drop_press(pick - 7);
            end
        end
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    initial begin
        void'($urandom(SEED));
        button           = '0;
        strobe           = 1'b0;
        game_state_in    = GAME_IDLE;
        playing_state_in = '0;
        activate_rand    = 1'b0;
        m_stage          = '0;
        m_ready          = 1'b0;
        m_clear          = 1'b0;
        m_pos            = '0;
        clear_history();
        seen = '{default: 1'b0};
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_flag(mem_error, 1'b0, "mem_error after reset");
        check_flag(puzzle_ready, 1'b0, "puzzle_ready after reset");
        check_outputs();
        // no puzzle drawn yet
        game_state_in    = GAME_RUN;
        playing_state_in = MODULE_ID;
        press(4'b0010);
        load_puzzle();
        play_correct(5);
        // already cleared
        press(4'b0001 << 2'($urandom));
        load_puzzle();
        play_correct(int'($urandom % 5));
        wrong_press();
        play_correct(5);
        load_puzzle();
        play_correct(2);
        for (int k = 0; k < 3; k++) begin
            drop_press(k);
        end
        play_correct(3);
        repeat (NUM_SESSIONS) run_session();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: mem_game.f
verilog/mem_game_pkg.sv
verilog/puzzle_source.sv
verilog/stage_slot.sv
verilog/press_judge.sv
verilog/mem_game.sv
test/clk_gen.sv
test/mem_game_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_game_tb
FILELIST  ?= mem_game.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
